// ==== armPipe.sv ====
`timescale 1ns/1ps
/*
 * Five-stage pipelined core, top level
 * Connects the stages and the hazard unit to the instruction memory,
 * data memory and register peek port
 */

module armPipe (
	input  logic           clk,
	input  logic           reset,
	input  cpuPkg::word    instr,
	input  cpuPkg::word    readData,
	input  cpuPkg::regAddr peekSel,
	output cpuPkg::word    pc,
	output cpuPkg::word    dataAddr,
	output cpuPkg::word    writeData,
	output cpuPkg::word    peekData,
	output logic           memWrite
);

	// Fetch to decode
	cpuPkg::word    instrD;
	cpuPkg::word    pcPlus4D;

	// Decode to execute
	cpuPkg::word    rd1E;
	cpuPkg::word    rd2E;
	cpuPkg::word    immE;
	cpuPkg::word    branchBaseE;
	cpuPkg::aluOp   aluOpE;
	logic           aluSrcE;
	logic           memWriteE;
	logic           branchE;

	// Memory and writeback
	cpuPkg::word    aluResultM;
	cpuPkg::word    writeDataM;
	logic           memWriteM;
	cpuPkg::word    resultW;
	cpuPkg::regAddr wa3W;
	logic           regWriteW;

	hazardIf hz (.clk(clk), .reset(reset));

	fetchStage i_fetchStage (
		.clk         (clk),
		.reset       (reset),
		.branchTarget(aluResultM),
		.hz          (hz),
		.instr       (instr),
		.pc          (pc),
		.instrD      (instrD),
		.pcPlus4D    (pcPlus4D)
	);

	decodeStage i_decodeStage (
		.clk        (clk),
		.reset      (reset),
		.instrD     (instrD),
		.pcPlus4D   (pcPlus4D),
		.hz         (hz),
		.wa3W       (wa3W),
		.regWriteW  (regWriteW),
		.resultW    (resultW),
		.peekSel    (peekSel),
		.peekData   (peekData),
		.rd1E       (rd1E),
		.rd2E       (rd2E),
		.immE       (immE),
		.branchBaseE(branchBaseE),
		.aluOpE     (aluOpE),
		.aluSrcE    (aluSrcE),
		.memWriteE  (memWriteE),
		.branchE    (branchE)
	);

	executeStage i_executeStage (
		.clk        (clk),
		.reset      (reset),
		.rd1E       (rd1E),
		.rd2E       (rd2E),
		.immE       (immE),
		.branchBaseE(branchBaseE),
		.aluOpE     (aluOpE),
		.aluSrcE    (aluSrcE),
		.memWriteE  (memWriteE),
		.branchE    (branchE),
		.hz         (hz),
		.resultW    (resultW),
		.aluResultM (aluResultM),
		.writeDataM (writeDataM),
		.memWriteM  (memWriteM)
	);

	writebackStage i_writebackStage (
		.clk       (clk),
		.reset     (reset),
		.aluResultM(aluResultM),
		.readData  (readData),
		.hz        (hz),
		.resultW   (resultW),
		.wa3W      (wa3W),
		.regWriteW (regWriteW)
	);

	hazardUnit i_hazardUnit (
		.hz(hz)
	);

	// Memory stage drives the data memory directly
	assign dataAddr  = aluResultM;
	assign writeData = writeDataM;
	assign memWrite  = memWriteM;

endmodule

// ==== armPipeTb.sv ====
`timescale 1ns/1ps
/*
 * Testbench for the five-stage core
 * Memory models, instruction encoder and directed programs that are
 * checked through the register peek port and the data memory
 */

module armPipeTb;

	logic           clk;
	logic           reset;
	cpuPkg::regAddr peekSel;
	cpuPkg::word    instr;
	cpuPkg::word    readData;
	cpuPkg::word    pc;
	cpuPkg::word    dataAddr;
	cpuPkg::word    writeData;
	cpuPkg::word    peekData;
	logic           memWrite;

	// 256 words each covering byte addresses 0x000..0x3FF
	cpuPkg::word imem [256];
	cpuPkg::word dmem [256];
	cpuPkg::word prog [$];
	// Every store the core performs, in order
	cpuPkg::word storeAddr [$];
	cpuPkg::word storeData [$];
	cpuPkg::word haltAddr;
	logic        fillRequest;
	int          fillIdx;

	armPipe i_armPipe (
		.clk      (clk),
		.reset    (reset),
		.instr    (instr),
		.readData (readData),
		.peekSel  (peekSel),
		.pc       (pc),
		.dataAddr (dataAddr),
		.writeData(writeData),
		.peekData (peekData),
		.memWrite (memWrite)
	);

	always #5 clk = ~clk;

	// ------------------------------------------------------------------------
	// Memory models
	// ------------------------------------------------------------------------
	// Both reads are combinational in the same cycle
	assign instr    = imem[pc[9:2]];
	assign readData = dmem[dataAddr[9:2]];

	// Fill pattern follows the whole word index
	function automatic cpuPkg::word fillWord(input int idx);
		return 32'hD000_0000 ^ (32'(idx) * 32'h0001_0001);
	endfunction

	always @(posedge clk) begin
		if (fillRequest) begin
			for (fillIdx = 0; fillIdx < 256; fillIdx++) begin
				dmem[fillIdx] <= fillWord(fillIdx);
			end
		end else if (memWrite) begin
			dmem[dataAddr[9:2]] <= writeData;
			storeAddr.push_back(dataAddr);
			storeData.push_back(writeData);
		end
	end

	// ------------------------------------------------------------------------
	// Instruction encoder
	// ------------------------------------------------------------------------
	function automatic cpuPkg::word dataProc(
		input logic [3:0]     cmd,
		input logic           immFlag,
		input cpuPkg::regAddr rd,
		input cpuPkg::regAddr rn,
		input logic [7:0]     op2
	);
		cpuPkg::instrWord w;
		w            = '0;
		w.dp.cond    = 4'hE;
		w.dp.op      = cpuPkg::classDp;
		w.dp.immFlag = immFlag;
		w.dp.cmd     = cmd;
		w.dp.rn      = rn;
		w.dp.rd      = rd;
		w.dp.imm8    = op2;
		return w;
	endfunction

	function automatic cpuPkg::word immOp(input logic [3:0] cmd, input cpuPkg::regAddr rd,
		input cpuPkg::regAddr rn, input logic [7:0] imm);
		return dataProc(cmd, 1'b1, rd, rn, imm);
	endfunction

	// Rm sits in the low nibble of imm8
	function automatic cpuPkg::word regOp(input logic [3:0] cmd, input cpuPkg::regAddr rd,
		input cpuPkg::regAddr rn, input cpuPkg::regAddr rm);
		return dataProc(cmd, 1'b0, rd, rn, {4'd0, rm});
	endfunction

	// Pre-indexed load or store with an added immediate offset
	function automatic cpuPkg::word memAccess(input logic load, input cpuPkg::regAddr rd,
		input cpuPkg::regAddr rn, input logic [11:0] offset);
		cpuPkg::instrWord w;
		w           = '0;
		w.mem.cond  = 4'hE;
		w.mem.op    = cpuPkg::classMem;
		w.mem.mode  = 5'b01100;
		w.mem.load  = load;
		w.mem.rn    = rn;
		w.mem.rd    = rd;
		w.mem.imm12 = offset;
		return w;
	endfunction

	// Word offset counted from PC+8
	function automatic cpuPkg::word branchTo(input cpuPkg::word from, input cpuPkg::word to);
		cpuPkg::instrWord w;
		cpuPkg::word      off;
		w          = '0;
		off        = (to - from - 32'd8) >> 2;
		w.mem.cond = 4'hE;
		w.mem.op   = cpuPkg::classBranch;
		w.mem.mode = 5'b10000;
		w[23:0]    = off[23:0];
		return w;
	endfunction

	// ------------------------------------------------------------------------
	// Checks and program control
	// ------------------------------------------------------------------------
	task automatic checkValue(input string name, input cpuPkg::word expected,
		input cpuPkg::word actual);
		if (actual !== expected) begin
			$display("Error %s expected %h got %h", name, expected, actual);
			$display("Test FAILED");
			$fatal(1, "value mismatch");
		end
	endtask

	// Registers are quiet while the core spins in the halt loop
	task automatic expectReg(input cpuPkg::regAddr r, input cpuPkg::word expected);
		@(negedge clk);
		peekSel = r;
		@(posedge clk);
		checkValue($sformatf("R%0d", r), expected, peekData);
	endtask

	task automatic appendHalt();
		haltAddr = 32'(prog.size() * 4);
		prog.push_back(branchTo(haltAddr, haltAddr));
	endtask

	task automatic initMemories();
		int i;
		// Class 3 words do nothing and their low bits show the address
		for (i = 0; i < 256; i++) begin
			imem[i] = 32'h0C00_0000 | 32'(i);
		end
		for (i = 0; i < prog.size(); i++) begin
			imem[i] = prog[i];
		end
		@(negedge clk);
		fillRequest = 1'b1;
		@(negedge clk);
		fillRequest = 1'b0;
		storeAddr.delete();
		storeData.delete();
	endtask

	task automatic applyReset();
		@(negedge clk);
		reset = 1'b1;
		repeat (2) begin
			@(negedge clk);
			checkValue("pc", 32'd0, pc);
			checkValue("memWrite", 32'd0, 32'(memWrite));
		end
		reset = 1'b0;
	endtask

	// Self branch keeps pc within haltAddr..haltAddr+12
	task automatic waitHalt();
		int inLoop;
		int cycles;
		inLoop = 0;
		cycles = 0;
		while (inLoop < 8) begin
			@(negedge clk);
			cycles++;
			if (pc >= haltAddr && pc <= haltAddr + 32'd12) begin
				inLoop++;
			end else begin
				inLoop = 0;
			end
			if (cycles > 400) begin
				$display("Timeout: core never settled in the halt loop at %h", haltAddr);
				$display("Test FAILED");
				$fatal(1, "halt timeout");
			end
		end
	endtask

	task automatic runProgram();
		appendHalt();
		initMemories();
		applyReset();
		waitHalt();
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------
	task automatic resetSequence();
		int k;
		prog.delete();
		for (k = 1; k <= 4; k++) begin
			prog.push_back(immOp(cpuPkg::cmdOrr, 4'(k), 4'd0, 8'(k)));
		end
		appendHalt();
		initMemories();
		applyReset();
		// Sequential fetch until the first branch reaches memory
		for (k = 1; k < 4; k++) begin
			@(negedge clk);
			checkValue("pc", 32'(4 * k), pc);
		end
		waitHalt();
		expectReg(4'd4, 32'd4);
	endtask

	task automatic aluOps();
		logic [7:0] a;
		logic [7:0] b;
		logic [7:0] k;
		a = 8'($urandom);
		b = 8'($urandom);
		k = 8'($urandom);
		prog.delete();
		prog.push_back(immOp(cpuPkg::cmdOrr, 4'd1, 4'd0, a));
		prog.push_back(immOp(cpuPkg::cmdOrr, 4'd2, 4'd0, b));
		prog.push_back(immOp(cpuPkg::cmdOrr, 4'd11, 4'd0, k));
		prog.push_back(regOp(cpuPkg::cmdAdd, 4'd3, 4'd1, 4'd2));
		prog.push_back(immOp(cpuPkg::cmdOrr, 4'd11, 4'd0, k));
		prog.push_back(regOp(cpuPkg::cmdSub, 4'd4, 4'd1, 4'd2));
		prog.push_back(immOp(cpuPkg::cmdOrr, 4'd11, 4'd0, k));
		prog.push_back(regOp(cpuPkg::cmdAnd, 4'd5, 4'd1, 4'd2));
		prog.push_back(immOp(cpuPkg::cmdOrr, 4'd11, 4'd0, k));
		prog.push_back(regOp(cpuPkg::cmdOrr, 4'd6, 4'd1, 4'd2));
		prog.push_back(immOp(cpuPkg::cmdAdd, 4'd7, 4'd1, k));
		prog.push_back(immOp(cpuPkg::cmdSub, 4'd8, 4'd2, k));
		prog.push_back(immOp(cpuPkg::cmdAnd, 4'd9, 4'd1, k));
		prog.push_back(immOp(cpuPkg::cmdOrr, 4'd10, 4'd2, k));
		runProgram();
		expectReg(4'd3, 32'(a) + 32'(b));
		expectReg(4'd4, 32'(a) - 32'(b));
		expectReg(4'd5, 32'(a) & 32'(b));
		expectReg(4'd6, 32'(a) | 32'(b));
		expectReg(4'd7, 32'(a) + 32'(k));
		expectReg(4'd8, 32'(b) - 32'(k));
		expectReg(4'd9, 32'(a) & 32'(k));
		expectReg(4'd10, 32'(b) | 32'(k));
	endtask

	// Each word uses the one before it and several also the one two back
	task automatic forwardChain();
		logic [7:0]  x;
		logic [7:0]  y;
		logic [7:0]  z;
		cpuPkg::word r2;
		cpuPkg::word r3;
		cpuPkg::word r4;
		cpuPkg::word r5;
		x = 8'($urandom);
		y = 8'($urandom);
		z = 8'($urandom);
		prog.delete();
		prog.push_back(immOp(cpuPkg::cmdOrr, 4'd1, 4'd0, x));
		prog.push_back(immOp(cpuPkg::cmdAdd, 4'd2, 4'd1, y));
		prog.push_back(regOp(cpuPkg::cmdSub, 4'd3, 4'd2, 4'd1));
		prog.push_back(regOp(cpuPkg::cmdAdd, 4'd4, 4'd3, 4'd2));
		prog.push_back(regOp(cpuPkg::cmdOrr, 4'd5, 4'd4, 4'd1));
		prog.push_back(immOp(cpuPkg::cmdSub, 4'd6, 4'd5, z));
		runProgram();
		r2 = 32'(x) + 32'(y);
		r3 = r2 - 32'(x);
		r4 = r3 + r2;
		r5 = r4 | 32'(x);
		expectReg(4'd2, r2);
		expectReg(4'd3, r3);
		expectReg(4'd4, r4);
		expectReg(4'd5, r5);
		expectReg(4'd6, r5 - 32'(z));
	endtask

	task automatic loadUse();
		logic [7:0]  hi;
		logic [7:0]  lo;
		cpuPkg::word value;
		hi    = 8'($urandom);
		lo    = 8'($urandom);
		value = {16'd0, hi, lo};
		prog.delete();
		// Eight doublings shift hi up by one byte
		prog.push_back(immOp(cpuPkg::cmdOrr, 4'd1, 4'd0, hi));
		repeat (8) prog.push_back(regOp(cpuPkg::cmdAdd, 4'd1, 4'd1, 4'd1));
		prog.push_back(immOp(cpuPkg::cmdOrr, 4'd1, 4'd1, lo));
		prog.push_back(immOp(cpuPkg::cmdOrr, 4'd2, 4'd0, 8'h40));
		prog.push_back(memAccess(1'b0, 4'd1, 4'd2, 12'h020));
		prog.push_back(memAccess(1'b1, 4'd3, 4'd2, 12'h020));
		prog.push_back(immOp(cpuPkg::cmdAdd, 4'd4, 4'd3, 8'd1));
		prog.push_back(regOp(cpuPkg::cmdAdd, 4'd5, 4'd3, 4'd3));
		runProgram();
		// Byte address 0x60 is word 24
		checkValue("dmem[0x60]", value, dmem[24]);
		checkValue("store count", 32'd1, 32'(storeAddr.size()));
		checkValue("dataAddr", 32'h0000_0060, storeAddr[0]);
		checkValue("writeData", value, storeData[0]);
		expectReg(4'd3, value);
		expectReg(4'd4, value + 32'd1);
		expectReg(4'd5, value + value);
	endtask

	task automatic branchSkip();
		logic [7:0]  k;
		cpuPkg::word at;
		k = 8'($urandom % 255 + 1);
		prog.delete();
		prog.push_back(immOp(cpuPkg::cmdOrr, 4'd6, 4'd0, 8'h80));
		prog.push_back(immOp(cpuPkg::cmdOrr, 4'd7, 4'd0, k));
		at = 32'(prog.size() * 4);
		prog.push_back(branchTo(at, at + 32'd20));
		// Skipped words with the store in the branch shadow
		prog.push_back(immOp(cpuPkg::cmdAdd, 4'd1, 4'd7, 8'd1));
		prog.push_back(immOp(cpuPkg::cmdAdd, 4'd2, 4'd7, 8'd2));
		prog.push_back(memAccess(1'b0, 4'd7, 4'd6, 12'h000));
		prog.push_back(immOp(cpuPkg::cmdAdd, 4'd3, 4'd7, 8'd3));
		prog.push_back(immOp(cpuPkg::cmdAdd, 4'd4, 4'd7, 8'd4));
		runProgram();
		expectReg(4'd1, 32'd0);
		expectReg(4'd2, 32'd0);
		expectReg(4'd3, 32'd0);
		expectReg(4'd4, 32'(k) + 32'd4);
		checkValue("dmem[0x80]", fillWord(32), dmem[32]);
		checkValue("store count", 32'd0, 32'(storeAddr.size()));
	endtask

	initial begin
		clk         = 1'b0;
		reset       = 1'b1;
		peekSel     = '0;
		fillRequest = 1'b0;
		haltAddr    = '0;
		void'($urandom(8));
		resetSequence();
		aluOps();
		forwardChain();
		loadUse();
		branchSkip();
		$display("Test OK");
		$finish;
	end

endmodule

// ==== cpuPkg.sv ====
/*
 * Core package
 * Widths, register indices, opcode and select encodings and the
 * instruction word layout shared by every stage of the pipeline
 */

package cpuPkg;

	// ------------------------------------------------------------------------
	// Widths and register file geometry
	// ------------------------------------------------------------------------
	localparam int dataWidth    = 32;
	localparam int regAddrWidth = 4;
	// R0..R14 are stored, R15 reads as zero
	localparam int regCount     = 15;

	typedef logic [dataWidth-1:0]    word;
	typedef logic [regAddrWidth-1:0] regAddr;
	typedef logic [1:0]              opClass;
	typedef logic [1:0]              aluOp;
	typedef logic [1:0]              fwdSel;

	localparam regAddr pcReg = 4'd15;

	// Instruction class, bits 27:26
	localparam opClass classDp     = 2'd0;
	localparam opClass classMem    = 2'd1;
	localparam opClass classBranch = 2'd2;

	// Data-processing commands that the decoder accepts
	localparam logic [3:0] cmdAnd = 4'd0;
	localparam logic [3:0] cmdSub = 4'd2;
	localparam logic [3:0] cmdAdd = 4'd4;
	localparam logic [3:0] cmdOrr = 4'd12;

	// ALU operations
	localparam aluOp aluAdd = 2'd0;
	localparam aluOp aluSub = 2'd1;
	localparam aluOp aluAnd = 2'd2;
	localparam aluOp aluOr  = 2'd3;

	// Operand source for the execute stage
	localparam fwdSel fwdReg = 2'd0;
	localparam fwdSel fwdMem = 2'd1;
	localparam fwdSel fwdWb  = 2'd2;

	// Bubble word, class 3 decodes to no register or memory write
	localparam word nopInstr = 32'h0C00_0000;

	// ------------------------------------------------------------------------
	// Instruction word, two views of the same 32 bits
	// ------------------------------------------------------------------------
	typedef union packed {
		struct packed {
			logic [3:0] cond;
			opClass     op;
			logic       immFlag;
			logic [3:0] cmd;
			logic       setFlags;
			regAddr     rn;
			regAddr     rd;
			logic [3:0] shift;
			// Low nibble doubles as Rm in the register form
			logic [7:0] imm8;
		} dp;
		struct packed {
			logic [3:0]  cond;
			opClass      op;
			logic [4:0]  mode;
			logic        load;
			regAddr      rn;
			regAddr      rd;
			logic [11:0] imm12;
		} mem;
	} instrWord;

endpackage

// ==== decodeStage.sv ====
`timescale 1ns/1ps
/*
 * Decode stage
 * Instruction decoder, register reads, immediate extension and the
 * decode/execute pipeline register
 */

module decodeStage (
	input  logic           clk,
	input  logic           reset,
	input  cpuPkg::word    instrD,
	input  cpuPkg::word    pcPlus4D,
	hazardIf.stage         hz,
	input  cpuPkg::regAddr wa3W,
	input  logic           regWriteW,
	input  cpuPkg::word    resultW,
	input  cpuPkg::regAddr peekSel,
	output cpuPkg::word    peekData,
	output cpuPkg::word    rd1E,
	output cpuPkg::word    rd2E,
	output cpuPkg::word    immE,
	output cpuPkg::word    branchBaseE,
	output cpuPkg::aluOp   aluOpE,
	output logic           aluSrcE,
	output logic           memWriteE,
	output logic           branchE
);

	cpuPkg::instrWord instr;
	logic             isDp;
	logic             isMem;
	logic             isBranch;
	logic             isLoad;
	logic             isStore;
	logic             useRm;
	logic             aluSrcD;
	logic             regWriteD;
	logic             bubbleE;
	cpuPkg::aluOp     aluOpD;
	cpuPkg::word      immD;
	cpuPkg::word      rd1D;
	cpuPkg::word      rd2D;

	assign instr = instrD;

	// ------------------------------------------------------------------------
	// Decoder
	// ------------------------------------------------------------------------
	assign isDp     = instr.dp.op == cpuPkg::classDp;
	assign isMem    = instr.mem.op == cpuPkg::classMem;
	assign isBranch = instr.dp.op == cpuPkg::classBranch;
	assign isLoad   = isMem && instr.mem.load;
	assign isStore  = isMem && !instr.mem.load;
	assign useRm    = isDp && !instr.dp.immFlag;

	// Unused source ports point at R15 so they never match a hazard
	assign hz.ra1D = isBranch ? cpuPkg::pcReg : instr.dp.rn;
	assign hz.ra2D = isStore ? instr.mem.rd :
	                 useRm   ? instr.dp.imm8[3:0] : cpuPkg::pcReg;

	assign aluSrcD   = !useRm;
	assign regWriteD = (isDp || isLoad) && instr.dp.rd != cpuPkg::pcReg;

	always_comb begin
		aluOpD = cpuPkg::aluAdd;
		if (isDp) begin
			case (instr.dp.cmd)
				cpuPkg::cmdSub: aluOpD = cpuPkg::aluSub;
				cpuPkg::cmdAnd: aluOpD = cpuPkg::aluAnd;
				cpuPkg::cmdOrr: aluOpD = cpuPkg::aluOr;
				default:        aluOpD = cpuPkg::aluAdd;
			endcase
		end
	end

	// Zero-extended imm8 or imm12, branch offset is a signed word count
	always_comb begin
		if (isBranch) begin
			immD = {{6{instr.mem[23]}}, instr.mem[23:0], 2'b00};
		end else if (isMem) begin
			immD = {20'd0, instr.mem.imm12};
		end else begin
			immD = {24'd0, instr.dp.imm8};
		end
	end

	regFile i_regFile (
		.clk     (clk),
		.reset   (reset),
		.ra1     (hz.ra1D),
		.ra2     (hz.ra2D),
		.wa3     (wa3W),
		.peekSel (peekSel),
		.we3     (regWriteW),
		.wd3     (resultW),
		.rd1     (rd1D),
		.rd2     (rd2D),
		.peekData(peekData)
	);

	// ------------------------------------------------------------------------
	// Decode/execute register
	// ------------------------------------------------------------------------
	// Killed by a taken branch, or held back behind a load
	assign bubbleE = hz.flush || hz.stall;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hz.regWriteE <= 1'b0;
			hz.loadE     <= 1'b0;
			memWriteE    <= 1'b0;
			branchE      <= 1'b0;
		end else begin
			hz.regWriteE <= regWriteD && !bubbleE;
			hz.loadE     <= isLoad && !bubbleE;
			memWriteE    <= isStore && !bubbleE;
			branchE      <= isBranch && !bubbleE;
		end
	end

	// Operands, selects and indices
	always_ff @(posedge clk) begin
		rd1E        <= rd1D;
		rd2E        <= rd2D;
		immE        <= immD;
		branchBaseE <= pcPlus4D + 32'd4;
		aluOpE      <= aluOpD;
		aluSrcE     <= aluSrcD;
		hz.ra1E     <= hz.ra1D;
		hz.ra2E     <= hz.ra2D;
		hz.wa3E     <= instr.dp.rd;
	end

endmodule

// ==== executeStage.sv ====
`timescale 1ns/1ps
/*
 * Execute stage
 * Forwarding muxes, ALU, branch target and the execute/memory register
 */

module executeStage (
	input  logic         clk,
	input  logic         reset,
	input  cpuPkg::word  rd1E,
	input  cpuPkg::word  rd2E,
	input  cpuPkg::word  immE,
	input  cpuPkg::word  branchBaseE,
	input  cpuPkg::aluOp aluOpE,
	input  logic         aluSrcE,
	input  logic         memWriteE,
	input  logic         branchE,
	hazardIf.stage       hz,
	input  cpuPkg::word  resultW,
	output cpuPkg::word  aluResultM,
	output cpuPkg::word  writeDataM,
	output logic         memWriteM
);

	cpuPkg::word fwdA;
	cpuPkg::word fwdB;
	cpuPkg::word srcA;
	cpuPkg::word srcB;
	cpuPkg::word aluResultE;

	// Register value, memory-stage result or writeback result
	always_comb begin
		case (hz.forwardA)
			cpuPkg::fwdMem: fwdA = aluResultM;
			cpuPkg::fwdWb:  fwdA = resultW;
			default:        fwdA = rd1E;
		endcase
		case (hz.forwardB)
			cpuPkg::fwdMem: fwdB = aluResultM;
			cpuPkg::fwdWb:  fwdB = resultW;
			default:        fwdB = rd2E;
		endcase
	end

	// Branch target is PC+8 plus the shifted offset
	assign srcA = branchE ? branchBaseE : fwdA;
	assign srcB = aluSrcE ? immE : fwdB;

	always_comb begin
		case (aluOpE)
			cpuPkg::aluSub: aluResultE = srcA - srcB;
			cpuPkg::aluAnd: aluResultE = srcA & srcB;
			cpuPkg::aluOr:  aluResultE = srcA | srcB;
			default:        aluResultE = srcA + srcB;
		endcase
	end

	// ------------------------------------------------------------------------
	// Execute/memory register
	// ------------------------------------------------------------------------
	// The word right behind a taken branch dies here
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			memWriteM    <= 1'b0;
			hz.regWriteM <= 1'b0;
			hz.loadM     <= 1'b0;
			hz.branchM   <= 1'b0;
		end else begin
			memWriteM    <= memWriteE && !hz.flush;
			hz.regWriteM <= hz.regWriteE && !hz.flush;
			hz.loadM     <= hz.loadE && !hz.flush;
			hz.branchM   <= branchE && !hz.flush;
		end
	end

	// Store data is the forwarded second register, not the immediate
	always_ff @(posedge clk) begin
		aluResultM <= aluResultE;
		writeDataM <= fwdB;
		hz.wa3M    <= hz.wa3E;
	end

endmodule

// ==== fetchStage.sv ====
`timescale 1ns/1ps
/*
 * Fetch stage
 * PC register with its incrementer and the fetch/decode pipeline register
 */

module fetchStage (
	input  logic        clk,
	input  logic        reset,
	input  cpuPkg::word branchTarget,
	hazardIf.stage      hz,
	input  cpuPkg::word instr,
	output cpuPkg::word pc,
	output cpuPkg::word instrD,
	output cpuPkg::word pcPlus4D
);

	cpuPkg::word pcPlus4;

	// Sequential next address
	assign pcPlus4 = pc + 32'd4;

	// A branch in memory wins over a stall
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (hz.flush) begin
			pc <= branchTarget;
		end else if (!hz.stall) begin
			pc <= pcPlus4;
		end
	end

	// ------------------------------------------------------------------------
	// Fetch/decode register
	// ------------------------------------------------------------------------
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			instrD <= cpuPkg::nopInstr;
		end else if (hz.flush) begin
			// Word fetched behind a taken branch
			instrD <= cpuPkg::nopInstr;
		end else if (!hz.stall) begin
			instrD <= instr;
		end
	end

	// PC+4 that travels with the word into decode
	always_ff @(posedge clk) begin
		if (!hz.stall) begin
			pcPlus4D <= pcPlus4;
		end
	end

	// Branch targets come from the ALU two stages later
	pcAligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("pc not word aligned: %h", pc);

endmodule

// ==== hazardIf.sv ====
`timescale 1ns/1ps
/*
 * Hazard bundle
 * Register indices and write enables from each stage toward the hazard
 * unit, and the stall, flush and forward selects coming back
 */

interface hazardIf (
	input logic clk,
	input logic reset
);
	// Decode-stage source registers
	cpuPkg::regAddr ra1D;
	cpuPkg::regAddr ra2D;

	// Execute stage
	cpuPkg::regAddr ra1E;
	cpuPkg::regAddr ra2E;
	cpuPkg::regAddr wa3E;
	logic           loadE;
	logic           regWriteE;

	// Memory stage
	cpuPkg::regAddr wa3M;
	logic           regWriteM;
	logic           loadM;
	logic           branchM;

	// Writeback stage
	cpuPkg::regAddr wa3W;
	logic           regWriteW;

	// Hazard unit decisions
	logic          stall;
	logic          flush;
	cpuPkg::fwdSel forwardA;
	cpuPkg::fwdSel forwardB;

	modport stage (
		input  stall, flush, forwardA, forwardB,
		output ra1D, ra2D, ra1E, ra2E, wa3E, loadE, regWriteE,
		output wa3M, regWriteM, loadM, branchM, wa3W, regWriteW
	);

	modport hazard (
		input  clk, reset,
		input  ra1D, ra2D, ra1E, ra2E, wa3E, loadE, regWriteE,
		input  wa3M, regWriteM, branchM, wa3W, regWriteW,
		output stall, flush, forwardA, forwardB
	);

endinterface

// ==== hazardUnit.sv ====
`timescale 1ns/1ps
/*
 * Hazard unit
 * Forward selects for execute, load-use stall and branch flush
 */

module hazardUnit (
	hazardIf.hazard hz
);

	logic loadUse;

	// Youngest producer wins and R15 is never forwarded
	function automatic cpuPkg::fwdSel pickForward(
		input cpuPkg::regAddr ra,
		input cpuPkg::regAddr wa3M,
		input logic           regWriteM,
		input cpuPkg::regAddr wa3W,
		input logic           regWriteW
	);
		if (ra == cpuPkg::pcReg) begin
			return cpuPkg::fwdReg;
		end
		if (regWriteM && wa3M == ra) begin
			return cpuPkg::fwdMem;
		end
		if (regWriteW && wa3W == ra) begin
			return cpuPkg::fwdWb;
		end
		return cpuPkg::fwdReg;
	endfunction

	assign hz.forwardA = pickForward(hz.ra1E, hz.wa3M, hz.regWriteM, hz.wa3W, hz.regWriteW);
	assign hz.forwardB = pickForward(hz.ra2E, hz.wa3M, hz.regWriteM, hz.wa3W, hz.regWriteW);

	// Load result is not ready until the end of memory
	assign loadUse = hz.loadE && (hz.wa3E == hz.ra1D || hz.wa3E == hz.ra2D);

	// A taken branch kills the stalled words anyway
	assign hz.flush = hz.branchM;
	assign hz.stall = loadUse && !hz.branchM;

	// ------------------------------------------------------------------------
	// Checks
	// ------------------------------------------------------------------------
	// The bubble moves the load on, so a stall never repeats
	stallOnce: assert property (@(posedge hz.clk) disable iff (hz.reset)
		hz.stall |=> !hz.stall)
		else $error("load-use stall lasted two cycles");

endmodule

// ==== regFile.sv ====
`timescale 1ns/1ps
/*
 * Register file
 * Fifteen registers, two write-through read ports and a peek port
 */

module regFile (
	input  logic           clk,
	input  logic           reset,
	input  cpuPkg::regAddr ra1,
	input  cpuPkg::regAddr ra2,
	input  cpuPkg::regAddr wa3,
	input  cpuPkg::regAddr peekSel,
	input  logic           we3,
	input  cpuPkg::word    wd3,
	output cpuPkg::word    rd1,
	output cpuPkg::word    rd2,
	output cpuPkg::word    peekData
);

	cpuPkg::word regs [cpuPkg::regCount];

	// R15 is zero, a same-cycle write is passed straight through
	function automatic cpuPkg::word readPort(input cpuPkg::regAddr ra);
		if (ra == cpuPkg::pcReg) begin
			return '0;
		end
		if (we3 && wa3 == ra) begin
			return wd3;
		end
		return regs[ra];
	endfunction

	assign rd1 = readPort(ra1);
	assign rd2 = readPort(ra2);

	// Peek sees the stored value only
	assign peekData = (peekSel == cpuPkg::pcReg) ? '0 : regs[peekSel];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < cpuPkg::regCount; i++) begin
				regs[i] <= '0;
			end
		end else if (we3 && wa3 != cpuPkg::pcReg) begin
			regs[wa3] <= wd3;
		end
	end

	// The decoder never lets an R15 destination reach writeback
	noPcWrite: assert property (@(posedge clk) disable iff (reset)
		!(we3 && wa3 == cpuPkg::pcReg))
		else $error("register write to R15");

endmodule

// ==== run.sh ====
#!/bin/sh
# Build the core testbench with Verilator and run it
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
	-f sim.f --top-module armPipeTb -o armPipeTb
./obj_dir/armPipeTb

// ==== sim.f ====
cpuPkg.sv
hazardIf.sv
fetchStage.sv
regFile.sv
decodeStage.sv
executeStage.sv
writebackStage.sv
hazardUnit.sv
armPipe.sv
armPipeTb.sv

// ==== writebackStage.sv ====
`timescale 1ns/1ps
/*
 * Writeback stage
 * Memory/writeback register and the load or ALU result select
 */

module writebackStage (
	input  logic           clk,
	input  logic           reset,
	input  cpuPkg::word    aluResultM,
	input  cpuPkg::word    readData,
	hazardIf.stage         hz,
	output cpuPkg::word    resultW,
	output cpuPkg::regAddr wa3W,
	output logic           regWriteW
);

	logic        loadW;
	cpuPkg::word aluResultW;
	cpuPkg::word readDataW;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			hz.regWriteW <= 1'b0;
			loadW        <= 1'b0;
		end else begin
			hz.regWriteW <= hz.regWriteM;
			loadW        <= hz.loadM;
		end
	end

	// Read data is sampled in the same cycle as the address
	always_ff @(posedge clk) begin
		aluResultW <= aluResultM;
		readDataW  <= readData;
		hz.wa3W    <= hz.wa3M;
	end

	assign resultW   = loadW ? readDataW : aluResultW;
	assign wa3W      = hz.wa3W;
	assign regWriteW = hz.regWriteW;

endmodule
